//--- filelist.f
logic/ecc_mem_pkg.sv
logic/ecc_47_cal.sv
logic/pipe_stage.sv
logic/axil_front.sv
logic/ecc_store.sv
logic/ecc_check.sv
logic/ecc_mem_top.sv
bench/ecc_mem_checker.sv
bench/ecc_mem_assertions.sv
bench/ecc_mem_tb.sv

//--- Bender.yml
package:
  name: ecc_mem

sources:
  - logic/ecc_mem_pkg.sv
  - logic/ecc_47_cal.sv
  - logic/pipe_stage.sv
  - logic/axil_front.sv
  - logic/ecc_store.sv
  - logic/ecc_check.sv
  - logic/ecc_mem_top.sv
  - target: simulation
    files:
      - bench/ecc_mem_checker.sv
      - bench/ecc_mem_assertions.sv
      - bench/ecc_mem_tb.sv

//--- bench/ecc_mem_tb.sv
`timescale 1ns/1ps

module ecc_mem_tb;
    import ecc_mem_pkg::*;

    localparam int DEPTH   = 256;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        arst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    int          check_errors;
    int          timeouts;
    int          seed;
    int          stall_seed;
    logic        stall_on;
    int          written_q[$];

    ecc_mem_top #(.DEPTH(DEPTH)) ecc_mem_top_i (.*);

    ecc_mem_checker #(.DEPTH(DEPTH)) ecc_mem_checker_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .errors(check_errors)
    );

    always #4 clk = ~clk;

    // Random RREADY and BREADY stalls only while a stall phase is running.
    always @(negedge clk) begin
        if (stall_on) begin
            rready = ($random(stall_seed) & 3) != 0;
            bready = ($random(stall_seed) & 3) != 0;
        end else begin
            rready = 1'b1;
            bready = 1'b1;
        end
    end

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // The AXI tasks start and end on a falling edge, so calls can run back to back.
    task automatic axi_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
        int n;
        arvalid = 1'b0;
        awaddr = a;
        wdata = d;
        wstrb = s;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        #1;
        while (!awready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!awready) note_timeout("write was never accepted");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] a);
        int n;
        awvalid = 1'b0;
        wvalid = 1'b0;
        araddr = a;
        arvalid = 1'b1;
        n = 0;
        #1;
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!arready) note_timeout("read was never accepted");
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (ecc_mem_checker_i.expected.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ecc_mem_checker_i.expected.size() != 0) note_timeout("responses never arrived");
    endtask

    task automatic arm_flips(input int b0, input int b1);
        logic [38:0] m;
        m = '0;
        m[b0] = 1'b1;
        if (b1 >= 0) m[b1] = 1'b1;
        axi_write(INJ_DATA, m[31:0], 4'hf);
        axi_write(INJ_PAR, {25'b0, m[38:32]}, 4'hf);
    endtask

    function automatic int pick_written();
        return written_q[$unsigned($random(seed)) % written_q.size()];
    endfunction

    task automatic flip_and_read(input int nflips);
        int idx;
        int b0;
        int b1;
        idx = pick_written();
        b0 = $unsigned($random(seed)) % 39;
        b1 = (b0 + 1 + $unsigned($random(seed)) % 38) % 39;
        arm_flips(b0, nflips > 1 ? b1 : -1);
        axi_write(12'(idx * 4), $random(seed), 4'hf);
        axi_read(12'(idx * 4));
        axi_read(nflips > 1 ? CNT_UNCORR : CNT_CORR);
    endtask

    initial begin
        int idx;
        int total;
        seed = 32'h97233b58;
        stall_seed = 32'h97233b58;
        stall_on = 1'b0;
        timeouts = 0;
        clk = 1'b0;
        arst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 16; i++) begin
            idx = $unsigned($random(seed)) % DEPTH;
            axi_write(12'(idx * 4), $random(seed), 4'hf);
            written_q.push_back(idx);
        end
        foreach (written_q[i]) axi_read(12'(written_q[i] * 4));

        for (int i = 0; i < 8; i++) flip_and_read(1);
        for (int i = 0; i < 4; i++) flip_and_read(2);
        axi_write(CNT_UNCORR, 32'h0, 4'hf);
        axi_read(CNT_UNCORR);

        // Bypass hands back raw words and leaves both counters alone.
        axi_write(CTRL, 32'h1, 4'hf);
        flip_and_read(1);
        flip_and_read(2);
        axi_read(CNT_CORR);
        axi_write(CTRL, 32'h0, 4'hf);
        axi_read(CTRL);

        idx = pick_written();
        axi_write(12'(idx * 4), $random(seed), 4'h3);
        axi_read(12'(idx * 4));
        axi_write(12'h500, $random(seed), 4'hf);
        axi_read(12'h500);
        axi_read(12'h7fc);

        drain();
        stall_on = 1'b1;
        for (int i = 0; i < 8; i++) axi_write(12'(pick_written() * 4), $random(seed), 4'hf);
        for (int i = 0; i < 24; i++) axi_read(12'(pick_written() * 4));
        drain();
        stall_on = 1'b0;
        drain();

        total = check_errors + timeouts + ecc_mem_top_i.ecc_mem_assertions_i.fails;
        $display("Errors: %0d compare, %0d assertion, %0d timeout", check_errors,
                 ecc_mem_top_i.ecc_mem_assertions_i.fails, timeouts);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bench/ecc_mem_assertions.sv
`timescale 1ns/1ps

module ecc_mem_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        awvalid,
    input logic        awready,
    input logic        arvalid,
    input logic        arready,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready
);

    int fails = 0;
    int outstanding;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(arvalid && arready) + int'(awvalid && awready)
                         - int'(bvalid && bready) - int'(rvalid && rready);
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid)
        else begin fails++; $error("AWVALID dropped before AWREADY"); end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid)
        else begin fails++; $error("ARVALID dropped before ARREADY"); end

    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin fails++; $error("B channel changed before BREADY"); end

    r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin fails++; $error("R channel changed before RREADY"); end

    rsp_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        (bvalid || rvalid) |-> outstanding != 0)
        else begin fails++; $error("Response without an accepted request"); end

endmodule

bind ecc_mem_top ecc_mem_assertions ecc_mem_assertions_i (.*);

//--- bench/ecc_mem_checker.sv
`timescale 1ns/1ps

module ecc_mem_checker #(
    parameter int DEPTH = 256
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    input  logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    input  logic        rready,
    output int          errors
);
    import ecc_mem_pkg::*;

    typedef struct packed {
        logic        is_read;
        logic        known;
        logic        check_data;
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [31:0] accepted;
    } rsp_exp_t;

    typedef struct packed {
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic        inc_corr;
        logic        inc_uncorr;
    } read_result_t;

    rsp_exp_t    expected[$];
    logic [31:0] mem_data [DEPTH];
    logic [31:0] mem_flip_data [DEPTH];
    logic [6:0]  mem_flip_par [DEPTH];
    logic        written [DEPTH];
    logic        bypass;
    logic [31:0] inj_data;
    logic [6:0]  inj_par;
    logic [31:0] cnt_corr;
    logic [31:0] cnt_uncorr;
    logic [31:0] cycle;
    logic [31:0] last_stall;

    // Expected outcome of a memory read, from the number of flipped stored bits.
    function automatic read_result_t expect_read(input logic [31:0] data,
                                                 input logic [31:0] flip_data,
                                                 input logic [6:0] flip_par,
                                                 input logic byp);
        read_result_t r;
        int flips;
        r = '0;
        flips = $countones(flip_data) + $countones(flip_par);
        r.resp = RESP_OKAY;
        r.rdata = data;
        if (byp) begin
            r.rdata = data ^ flip_data;
        end else if (flips == 1) begin
            r.inc_corr = 1'b1;
        end else if (flips >= 2) begin
            r.resp = RESP_SLVERR;
            r.inc_uncorr = 1'b1;
        end
        return r;
    endfunction

    task automatic apply_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
        rsp_exp_t e;
        logic [11:0] wa;
        wa = {a[11:2], 2'b00};
        e = '0;
        e.accepted = cycle;
        e.known = 1'b1;
        e.resp = RESP_OKAY;
        if (s != 4'hf) begin
            e.resp = RESP_SLVERR;
        end else if (wa < DEPTH * 4) begin
            mem_data[wa[11:2]] = d;
            mem_flip_data[wa[11:2]] = inj_data;
            mem_flip_par[wa[11:2]] = inj_par;
            written[wa[11:2]] = 1'b1;
            inj_data = '0;
            inj_par = '0;
        end else begin
            case (wa)
                CTRL:       bypass = d[0];
                INJ_DATA:   inj_data = d;
                INJ_PAR:    inj_par = d[6:0];
                CNT_CORR:   cnt_corr = '0;
                CNT_UNCORR: cnt_uncorr = '0;
                default:    e.resp = RESP_SLVERR;
            endcase
        end
        expected.push_back(e);
    endtask

    task automatic apply_read(input logic [11:0] a);
        rsp_exp_t e;
        read_result_t r;
        logic [11:0] ra;
        ra = {a[11:2], 2'b00};
        e = '0;
        e.accepted = cycle;
        e.is_read = 1'b1;
        e.known = 1'b1;
        e.check_data = 1'b1;
        e.resp = RESP_OKAY;
        if (ra < DEPTH * 4) begin
            if (!written[ra[11:2]]) begin
                e.known = 1'b0;
                e.check_data = 1'b0;
            end else begin
                r = expect_read(mem_data[ra[11:2]], mem_flip_data[ra[11:2]],
                                mem_flip_par[ra[11:2]], bypass);
                e.resp = r.resp;
                e.rdata = r.rdata;
                e.check_data = r.resp == RESP_OKAY;
                if (r.inc_corr) cnt_corr = cnt_corr + 1;
                if (r.inc_uncorr) cnt_uncorr = cnt_uncorr + 1;
            end
        end else begin
            case (ra)
                CTRL:       e.rdata = {31'b0, bypass};
                INJ_DATA:   e.rdata = inj_data;
                INJ_PAR:    e.rdata = {25'b0, inj_par};
                CNT_CORR:   e.rdata = cnt_corr;
                CNT_UNCORR: e.rdata = cnt_uncorr;
                default: begin
                    e.resp = RESP_SLVERR;
                    e.rdata = '0;
                end
            endcase
        end
        expected.push_back(e);
    endtask

    task automatic compare_rsp(input logic is_read, input logic [1:0] resp,
                               input logic [31:0] data);
        rsp_exp_t e;
        if (expected.size() == 0) begin
            $display("ERROR %0t: response with no outstanding request", $time);
            errors++;
        end else begin
            e = expected.pop_front();
            if (e.is_read != is_read) begin
                $display("ERROR %0t: response on the wrong channel (read=%0b)", $time, is_read);
                errors++;
            end else begin
                if (e.known && resp != e.resp) begin
                    $display("ERROR %0t: resp %0d, expected %0d", $time, resp, e.resp);
                    errors++;
                end else if (e.check_data && data != e.rdata) begin
                    $display("ERROR %0t: rdata %h, expected %h", $time, data, e.rdata);
                    errors++;
                end
                // Without back-pressure a response leaves 3 cycles after its request.
                if (last_stall < e.accepted && cycle - e.accepted != 3) begin
                    $display("ERROR %0t: response after %0d cycles, expected 3", $time,
                             cycle - e.accepted);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        errors = 0;
    end

    // Requests are modelled in acceptance order, which is also the response order.
    always @(posedge clk) begin
        if (!arst_n) begin
            expected.delete();
            foreach (written[i]) written[i] = 1'b0;
            bypass = 1'b0;
            inj_data = '0;
            inj_par = '0;
            cnt_corr = '0;
            cnt_uncorr = '0;
            cycle = '0;
            last_stall = '0;
        end else begin
            cycle = cycle + 1;
            if ((bvalid && !bready) || (rvalid && !rready)) last_stall = cycle;
            if (awready != wready) begin
                $display("ERROR %0t: AWREADY and WREADY differ", $time);
                errors++;
            end
            if (bvalid && bready) compare_rsp(1'b0, bresp, 32'h0);
            if (rvalid && rready) compare_rsp(1'b1, rresp, rdata);
            if (awvalid && awready) apply_write(awaddr, wdata, wstrb);
            if (arvalid && arready) apply_read(araddr);
        end
    end

endmodule

//--- logic/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top #(
    parameter int DEPTH = 256
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import ecc_mem_pkg::*;

    mem_req_t req;
    mem_req_t stage_req;
    stored_t  st;
    mem_rsp_t chk_rsp;
    mem_rsp_t rsp;
    logic     req_valid;
    logic     req_ready;
    logic     stage_valid;
    logic     stage_ready;
    logic     st_valid;
    logic     st_ready;
    logic     chk_valid;
    logic     chk_ready;
    logic     rsp_valid;
    logic     rsp_ready;

    axil_front #(.DEPTH(DEPTH)) axil_front_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    pipe_stage #(.payload_t(mem_req_t)) pipe_a_i (
        .clk(clk), .arst_n(arst_n),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(stage_valid), .out_ready(stage_ready), .out_data(stage_req)
    );

    ecc_store #(.DEPTH(DEPTH)) ecc_store_i (
        .clk(clk), .arst_n(arst_n),
        .in_valid(stage_valid), .in_ready(stage_ready), .in(stage_req),
        .out_valid(st_valid), .out_ready(st_ready), .out(st)
    );

    ecc_check ecc_check_i (
        .clk(clk), .arst_n(arst_n),
        .in(st), .in_valid(st_valid), .in_ready(st_ready),
        .out_valid(chk_valid), .out_ready(chk_ready), .out(chk_rsp)
    );

    pipe_stage #(.payload_t(mem_rsp_t)) pipe_b_i (
        .clk(clk), .arst_n(arst_n),
        .in_valid(chk_valid), .in_ready(chk_ready), .in_data(chk_rsp),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp)
    );

endmodule

//--- logic/ecc_check.sv
`timescale 1ns/1ps

module ecc_check (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ecc_mem_pkg::stored_t  in,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic                  out_valid,
    input  logic                  out_ready,
    output ecc_mem_pkg::mem_rsp_t out
);
    import ecc_mem_pkg::*;

    logic [ECC_DATA_W-1:0] fixed;
    logic [ECC_DATA_W-1:0] mask;
    logic                  sbit_err;
    logic                  dbit_err;
    logic                  tag_fault;
    logic                  uncorr;
    logic                  fire;
    logic [WORD_W-1:0]     cnt_corr;
    logic [WORD_W-1:0]     cnt_uncorr;

    ecc_47_cal ecc_47_cal_i (
        .data_in   ({in.req.idx, in.rd_word}),
        .data_out  (fixed),
        .parity_in (in.rd_par),
        .parity_out(),
        .bypass    (in.req.bypass),
        .mask      (mask),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

    assign in_ready = out_ready;
    assign out_valid = in_valid;
    assign fire = in_valid && out_ready;

    // A fix that lands in the tag means the word came from the wrong address.
    assign tag_fault = |mask[ECC_DATA_W-1:WORD_W];
    assign uncorr = dbit_err || tag_fault;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_corr   <= '0;
            cnt_uncorr <= '0;
        end else if (fire && in.req.op == CLEAR_CNT) begin
            if (in.req.idx[0]) cnt_corr <= '0;
            if (in.req.idx[1]) cnt_uncorr <= '0;
        end else if (fire && in.req.op == READ_MEM) begin
            if (sbit_err && !tag_fault && cnt_corr != '1) cnt_corr <= cnt_corr + 1'b1;
            if (uncorr && cnt_uncorr != '1) cnt_uncorr <= cnt_uncorr + 1'b1;
        end
    end

    always_comb begin
        out = '0;
        case (in.req.op)
            READ_MEM: begin
                out.is_read = 1'b1;
                out.rdata   = fixed[WORD_W-1:0];
                out.resp    = uncorr ? RESP_SLVERR : RESP_OKAY;
            end
            READ_CFG: begin
                out.is_read = 1'b1;
                out.rdata   = in.req.cfg_rdata;
            end
            READ_CNT: begin
                out.is_read = 1'b1;
                out.rdata   = in.req.idx[0] ? cnt_uncorr : cnt_corr;
            end
            REJECT_RD: begin
                out.is_read = 1'b1;
                out.resp    = RESP_SLVERR;
            end
            REJECT_WR: out.resp = RESP_SLVERR;
            default:   out.resp = RESP_OKAY;
        endcase
    end

endmodule

//--- logic/ecc_store.sv
`timescale 1ns/1ps

module ecc_store #(
    parameter int DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  ecc_mem_pkg::mem_req_t in,
    output logic                  out_valid,
    input  logic                  out_ready,
    output ecc_mem_pkg::stored_t  out
);
    import ecc_mem_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [ECC_PAR_W+WORD_W-1:0] mem [DEPTH];
    logic [AW-1:0]               addr;
    logic [ECC_PAR_W-1:0]        par;
    logic                        fire;

    assign in_ready = !out_valid || out_ready;
    assign fire     = in_valid && in_ready;
    assign addr     = in.idx[AW-1:0];

    // The word index is part of the codeword, so a wrong row shows up on read.
    assign par = ecc_encode({in.idx, in.wdata});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out.req <= in;
            if (in.op == WRITE_MEM) begin
                mem[addr] <= {par ^ in.inject_par, in.wdata ^ in.inject_data};
            end
            if (in.op == READ_MEM) begin
                {out.rd_par, out.rd_word} <= mem[addr];
            end else begin
                {out.rd_par, out.rd_word} <= '0;
            end
        end
    end

endmodule

//--- logic/axil_front.sv
`timescale 1ns/1ps

module axil_front #(
    parameter int DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [11:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [11:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  req_valid,
    input  logic                  req_ready,
    output ecc_mem_pkg::mem_req_t req,
    input  logic                  rsp_valid,
    output logic                  rsp_ready,
    input  ecc_mem_pkg::mem_rsp_t rsp
);
    import ecc_mem_pkg::*;

    localparam logic [11:0] MEM_END = 12'(DEPTH * 4);

    logic [11:0]          addr;
    logic                 wr_full;
    logic                 wr_fire;
    logic                 bypass;
    logic                 inj_arm;
    logic [WORD_W-1:0]    inj_mask_data;
    logic [ECC_PAR_W-1:0] inj_mask_par;

    // Reads take priority when both kinds are pending.
    assign addr      = arvalid ? {araddr[11:2], 2'b00} : {awaddr[11:2], 2'b00};
    assign wr_full   = wstrb == 4'hf;
    assign req_valid = arvalid || (awvalid && wvalid);
    assign arready   = arvalid && req_ready;
    assign wr_fire   = awvalid && wvalid && !arvalid && req_ready;
    assign awready   = wr_fire;
    assign wready    = wr_fire;

    always_comb begin
        req        = '0;
        req.bypass = bypass;
        req.idx    = TAG_W'(addr[11:2]);
        if (arvalid) begin
            if (addr < MEM_END) begin
                req.op = READ_MEM;
            end else begin
                case (addr)
                    CTRL: begin
                        req.op        = READ_CFG;
                        req.cfg_rdata = {31'b0, bypass};
                    end
                    INJ_DATA: begin
                        req.op        = READ_CFG;
                        req.cfg_rdata = inj_mask_data;
                    end
                    INJ_PAR: begin
                        req.op        = READ_CFG;
                        req.cfg_rdata = {25'b0, inj_mask_par};
                    end
                    CNT_CORR, CNT_UNCORR: begin
                        req.op  = READ_CNT;
                        req.idx = TAG_W'(addr == CNT_UNCORR);
                    end
                    default: req.op = REJECT_RD;
                endcase
            end
        end else if (!wr_full) begin
            req.op = REJECT_WR;
        end else if (addr < MEM_END) begin
            req.op    = WRITE_MEM;
            req.wdata = wdata;
            if (inj_arm) begin
                req.inject_data = inj_mask_data;
                req.inject_par  = inj_mask_par;
            end
        end else begin
            // Config writes are done here and travel on as a clear of no counter.
            req.op = CLEAR_CNT;
            case (addr)
                CTRL, INJ_DATA, INJ_PAR: req.idx = '0;
                CNT_CORR:                req.idx = TAG_W'(1);
                CNT_UNCORR:              req.idx = TAG_W'(2);
                default:                 req.op  = REJECT_WR;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bypass        <= 1'b0;
            inj_arm       <= 1'b0;
            inj_mask_data <= '0;
            inj_mask_par  <= '0;
        end else if (wr_fire && wr_full) begin
            if (addr == CTRL) begin
                bypass <= wdata[0];
            end
            if (addr == INJ_DATA) begin
                inj_mask_data <= wdata;
                inj_arm       <= 1'b1;
            end
            if (addr == INJ_PAR) begin
                inj_mask_par <= wdata[ECC_PAR_W-1:0];
                inj_arm      <= 1'b1;
            end
            // The masks are used once, by the next memory write.
            if (req.op == WRITE_MEM) begin
                inj_arm       <= 1'b0;
                inj_mask_data <= '0;
                inj_mask_par  <= '0;
            end
        end
    end

    assign bvalid    = rsp_valid && !rsp.is_read;
    assign rvalid    = rsp_valid && rsp.is_read;
    assign rsp_ready = rsp.is_read ? rready : bready;
    assign bresp     = rsp.resp;
    assign rresp     = rsp.resp;
    assign rdata     = rsp.rdata;

endmodule

//--- logic/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // The slice takes a new entry when it is empty or its entry leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- logic/ecc_47_cal.sv
`timescale 1ns/1ps

module ecc_47_cal (
    input  logic [ecc_mem_pkg::ECC_DATA_W-1:0] data_in,
    output logic [ecc_mem_pkg::ECC_DATA_W-1:0] data_out,
    input  logic [ecc_mem_pkg::ECC_PAR_W-1:0]  parity_in,
    output logic [ecc_mem_pkg::ECC_PAR_W-1:0]  parity_out,
    input  logic                               bypass,
    output logic [ecc_mem_pkg::ECC_DATA_W-1:0] mask,
    output logic                               sbit_err,
    output logic                               dbit_err
);
    import ecc_mem_pkg::*;

    logic [ECC_PAR_W-1:0] syndrome;
    logic [5:0]           pos;
    logic                 hit;
    logic                 par_only;

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // A syndrome with a single bit set points at a flipped parity bit.
    assign par_only = $onehot(syndrome);

    assign mask     = (hit && !bypass) ? ECC_DATA_W'(1) << pos : '0;
    assign data_out = data_in ^ mask;
    assign sbit_err = !bypass && (hit || par_only);
    assign dbit_err = !bypass && (syndrome != '0) && !hit && !par_only;

    always_comb begin
        hit = 1'b1;
        pos = '0;
        case (syndrome)
            7'b1000011: pos = 6'd0;
            7'b1000101: pos = 6'd1;
            7'b1000110: pos = 6'd2;
            7'b0000111: pos = 6'd3;
            7'b1001001: pos = 6'd4;
            7'b1001010: pos = 6'd5;
            7'b0001011: pos = 6'd6;
            7'b1001100: pos = 6'd7;
            7'b0001101: pos = 6'd8;
            7'b0001110: pos = 6'd9;
            7'b1001111: pos = 6'd10;
            7'b1010001: pos = 6'd11;
            7'b1010010: pos = 6'd12;
            7'b0010011: pos = 6'd13;
            7'b1010100: pos = 6'd14;
            7'b0010101: pos = 6'd15;
            7'b0010110: pos = 6'd16;
            7'b1010111: pos = 6'd17;
            7'b1011000: pos = 6'd18;
            7'b0011001: pos = 6'd19;
            7'b0011010: pos = 6'd20;
            7'b1011011: pos = 6'd21;
            7'b0011100: pos = 6'd22;
            7'b1011101: pos = 6'd23;
            7'b1011110: pos = 6'd24;
            7'b0011111: pos = 6'd25;
            7'b1100001: pos = 6'd26;
            7'b1100010: pos = 6'd27;
            7'b0100011: pos = 6'd28;
            7'b1100100: pos = 6'd29;
            7'b0100101: pos = 6'd30;
            7'b0100110: pos = 6'd31;
            7'b1100111: pos = 6'd32;
            7'b1101000: pos = 6'd33;
            7'b0101001: pos = 6'd34;
            7'b0101010: pos = 6'd35;
            7'b1101011: pos = 6'd36;
            7'b0101100: pos = 6'd37;
            7'b1101101: pos = 6'd38;
            7'b1101110: pos = 6'd39;
            7'b0101111: pos = 6'd40;
            7'b1110000: pos = 6'd41;
            7'b0110001: pos = 6'd42;
            7'b0110010: pos = 6'd43;
            7'b1110011: pos = 6'd44;
            7'b0110100: pos = 6'd45;
            7'b1110101: pos = 6'd46;
            default:    hit = 1'b0;
        endcase
    end

endmodule

//--- logic/ecc_mem_pkg.sv
package ecc_mem_pkg;

    localparam int ECC_DATA_W = 47;
    localparam int ECC_PAR_W  = 7;
    localparam int WORD_W     = 32;
    localparam int TAG_W      = 15;

    localparam logic [11:0] CTRL       = 12'h400;
    localparam logic [11:0] INJ_DATA   = 12'h404;
    localparam logic [11:0] INJ_PAR    = 12'h408;
    localparam logic [11:0] CNT_CORR   = 12'h40c;
    localparam logic [11:0] CNT_UNCORR = 12'h410;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        WRITE_MEM,
        READ_MEM,
        READ_CFG,
        READ_CNT,
        CLEAR_CNT,
        REJECT_WR,
        REJECT_RD
    } mem_op_e;

    typedef struct packed {
        mem_op_e                op;
        logic [TAG_W-1:0]       idx;
        logic [WORD_W-1:0]      wdata;
        logic [WORD_W-1:0]      cfg_rdata;
        logic [WORD_W-1:0]      inject_data;
        logic [ECC_PAR_W-1:0]   inject_par;
        logic                   bypass;
    } mem_req_t;

    typedef struct packed {
        mem_req_t               req;
        logic [WORD_W-1:0]      rd_word;
        logic [ECC_PAR_W-1:0]   rd_par;
    } stored_t;

    typedef struct packed {
        logic                   is_read;
        logic [1:0]             resp;
        logic [WORD_W-1:0]      rdata;
    } mem_rsp_t;

    // Parity bit k is the XOR of the codeword bits whose column has bit k set.
    function automatic logic [ECC_PAR_W-1:0] ecc_encode(input logic [ECC_DATA_W-1:0] d);
        logic [ECC_PAR_W-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^ d[17]
             ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32] ^ d[34] ^ d[36]
             ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^ d[17]
             ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32] ^ d[35] ^ d[36]
             ^ d[39] ^ d[40] ^ d[43] ^ d[44];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32] ^ d[37] ^ d[38]
             ^ d[39] ^ d[40] ^ d[45] ^ d[46];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]);
        p[4] = (^d[25:11]) ^ (^d[46:41]);
        p[5] = ^d[46:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^ d[17]
             ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32] ^ d[33] ^ d[36]
             ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46];
        return p;
    endfunction

endpackage
